// File: project.f
tom_pkg.sv
tom_reg_decode.sv
tom_video_timing.sv
tom_pit.sv
tom_int_ctrl.sv
tom_top.sv
tb_tom_top.sv

// File: tb_tom_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the video timing and interrupt block
// Cycle model of beam, timer and pending bits, compared every clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_tom_top;
	import tom_pkg::*;

	// Cycle budget of each test, the watchdog adds slack on top
	localparam int T_RESET = 10;
	localparam int T_REGS = 60;
	localparam int T_VIDEO = 200;
	localparam int T_VINT = 200;
	localparam int T_PIT = 140;
	localparam int T_DSP = 40;
	localparam int TIMEOUT_CYCLES = T_RESET + T_REGS + T_VIDEO + T_VINT + T_PIT + T_DSP + 200;

	// INT1 bits the model tracks, DSP pending is checked by window
	localparam logic [TOM_DATA_W-1:0] INT1_CHK_MASK = 16'h0703;

	logic clk;
	logic rst_n_i;
	logic [TOM_ADDR_W-1:0] addr_i;
	logic [TOM_DATA_W-1:0] wdata_i;
	logic wr_i;
	logic rd_i;
	logic dint_i;
	logic [TOM_DATA_W-1:0] rdata_o;
	logic rvalid_o;
	logic hblank_o;
	logic vblank_o;
	logic blank_o;
	logic hsync_n_o;
	logic vsync_n_o;
	logic intl_o;

	int errors;
	int checks;
	int cycles;
	int last_vint_cyc;
	logic vid_chk;

	// Model copy of the registers and counters
	logic m_viden;
	logic [TOM_CNT_W-1:0] m_hc;
	logic [TOM_CNT_W-1:0] m_vc;
	logic [TOM_CNT_W-1:0] m_hp;
	logic [TOM_CNT_W-1:0] m_hbb;
	logic [TOM_CNT_W-1:0] m_hs;
	logic [TOM_CNT_W-1:0] m_vp;
	logic [TOM_CNT_W-1:0] m_vbb;
	logic [TOM_CNT_W-1:0] m_vs;
	logic [TOM_CNT_W-1:0] m_vi;
	logic [TOM_DATA_W-1:0] m_pit0;
	logic [TOM_DATA_W-1:0] m_pit1;
	longint m_pit_ph;
	logic [TOM_INT_N-1:0] m_en;
	logic m_pend_vid;
	logic m_pend_pit;
	logic [5:0] m_vid_now;
	logic m_tick;
	logic [TOM_INT_N-1:0] m_clr;
	logic [5:0] cmp_vid;

	// Model view in the cycle where rd_i is sampled
	logic [TOM_CNT_W-1:0] snap_hc;
	logic [TOM_CNT_W-1:0] snap_vc;
	logic [TOM_DATA_W-1:0] snap_int1;
	int snap_cyc;

	tom_top UUT (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.addr_i    (addr_i),
		.wdata_i   (wdata_i),
		.wr_i      (wr_i),
		.rd_i      (rd_i),
		.dint_i    (dint_i),
		.rdata_o   (rdata_o),
		.rvalid_o  (rvalid_o),
		.hblank_o  (hblank_o),
		.vblank_o  (vblank_o),
		.blank_o   (blank_o),
		.hsync_n_o (hsync_n_o),
		.vsync_n_o (vsync_n_o),
		.intl_o    (intl_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Watchdog, also the cycle index used by the timing checks
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	// Expected {hblank, vblank, blank, hsync_n, vsync_n, vint}
	function automatic logic [5:0] expected_video(input logic en,
			input logic [TOM_CNT_W-1:0] hc, input logic [TOM_CNT_W-1:0] vc);
		logic hb;
		logic vb;
		if (!en) begin
			return 6'b111110;
		end
		hb = (hc >= m_hbb);
		vb = (vc >= m_vbb);
		return {hb, vb, hb | vb, ~(hc >= m_hs), ~(vc >= m_vs), (hc == '0) && (vc == m_vi)};
	endfunction

	function automatic longint timer_period(input logic [TOM_DATA_W-1:0] p0,
			input logic [TOM_DATA_W-1:0] p1);
		return (longint'(p0) + 1) * (longint'(p1) + 1);
	endfunction

	// Timing registers are counter wide, the rest use the full bus
	function automatic logic [TOM_DATA_W-1:0] readback_mask(input logic [TOM_ADDR_W-1:0] a);
		if (a == ADDR_VMODE || a == ADDR_PIT0 || a == ADDR_PIT1) begin
			return '1;
		end
		return {{(TOM_DATA_W-TOM_CNT_W){1'b0}}, {TOM_CNT_W{1'b1}}};
	endfunction

	task automatic fail_value(input string msg, input logic [31:0] exp, input logic [31:0] got);
		$display("CHECK FAILED at %0t ns: %s, expected %0h, got %0h", $time, msg, exp, got);
		errors++;
	endtask

	task automatic fail_event(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		errors++;
	endtask

	// Model steps on the same edge as the DUT, inputs seen before the NBA update
	always @(posedge clk) begin
		if (!rst_n_i) begin
			m_viden = 1'b0;
			m_hc = '0;
			m_vc = '0;
			m_hp = '0;
			m_hbb = '0;
			m_hs = '0;
			m_vp = '0;
			m_vbb = '0;
			m_vs = '0;
			m_vi = '0;
			m_pit0 = '0;
			m_pit1 = '0;
			m_pit_ph = 0;
			m_en = '0;
			m_pend_vid = 1'b0;
			m_pend_pit = 1'b0;
		end else begin
			m_vid_now = expected_video(m_viden, m_hc, m_vc);
			m_tick = (m_pit0 != '0) && (m_pit1 != '0)
				&& (m_pit_ph == timer_period(m_pit0, m_pit1) - 1);
			m_clr = (wr_i && addr_i == ADDR_INT1) ? wdata_i[INT_CLR_LSB +: TOM_INT_N] : '0;
			// New event wins over a clear in the same cycle
			m_pend_vid = (m_pend_vid & ~m_clr[INT_VID]) | m_vid_now[0];
			m_pend_pit = (m_pend_pit & ~m_clr[INT_PIT]) | m_tick;
			if (wr_i && addr_i == ADDR_INT1) begin
				m_en = wdata_i[TOM_INT_N-1:0];
			end
			// Timer phase restarts on any PIT write
			if (wr_i && (addr_i == ADDR_PIT0 || addr_i == ADDR_PIT1)) begin
				m_pit_ph = 0;
			end else if (m_pit_ph >= timer_period(m_pit0, m_pit1) - 1) begin
				m_pit_ph = 0;
			end else begin
				m_pit_ph++;
			end
			// Beam runs 0..HP per line, 0..VP per frame
			if (!m_viden) begin
				m_hc = '0;
				m_vc = '0;
			end else if (m_hc == m_hp) begin
				m_hc = '0;
				m_vc = (m_vc == m_vp) ? '0 : m_vc + 1'b1;
			end else begin
				m_hc = m_hc + 1'b1;
			end
			if (wr_i) begin
				case (addr_i)
					ADDR_VMODE: m_viden = wdata_i[VMODE_VIDEN];
					ADDR_HP: m_hp = wdata_i[TOM_CNT_W-1:0];
					ADDR_HBB: m_hbb = wdata_i[TOM_CNT_W-1:0];
					ADDR_HS: m_hs = wdata_i[TOM_CNT_W-1:0];
					ADDR_VP: m_vp = wdata_i[TOM_CNT_W-1:0];
					ADDR_VBB: m_vbb = wdata_i[TOM_CNT_W-1:0];
					ADDR_VS: m_vs = wdata_i[TOM_CNT_W-1:0];
					ADDR_VI: m_vi = wdata_i[TOM_CNT_W-1:0];
					ADDR_PIT0: m_pit0 = wdata_i;
					ADDR_PIT1: m_pit1 = wdata_i;
					default: ;
				endcase
			end
		end
	end

	// Video outputs compared mid-cycle once the model is aligned
	always @(negedge clk) begin
		if (vid_chk) begin
			cmp_vid = expected_video(m_viden, m_hc, m_vc);
			checks++;
			assert ({hblank_o, vblank_o, blank_o, hsync_n_o, vsync_n_o} === cmp_vid[5:1])
			else fail_value("video {hblank,vblank,blank,hsync_n,vsync_n}", 32'(cmp_vid[5:1]),
				32'({hblank_o, vblank_o, blank_o, hsync_n_o, vsync_n_o}));
			if (cmp_vid[0]) begin
				last_vint_cyc = cycles;
			end
		end
	end

	task automatic reg_write(input logic [TOM_ADDR_W-1:0] a, input logic [TOM_DATA_W-1:0] d);
		@(posedge clk);
		addr_i <= a;
		wdata_i <= d;
		wr_i <= 1'b1;
		@(posedge clk);
		wr_i <= 1'b0;
	endtask

	// Returns mid-cycle after rvalid_o, snapshots the model at the sample cycle
	task automatic reg_read(input logic [TOM_ADDR_W-1:0] a, output logic [TOM_DATA_W-1:0] d);
		@(posedge clk);
		addr_i <= a;
		rd_i <= 1'b1;
		@(negedge clk);
		snap_hc = m_hc;
		snap_vc = m_vc;
		snap_int1 = '0;
		snap_int1[INT_CLR_LSB +: TOM_INT_N] = m_en;
		snap_int1[INT_VID] = m_pend_vid;
		snap_int1[INT_PIT] = m_pend_pit;
		snap_cyc = cycles;
		checks++;
		assert (rvalid_o === 1'b0) else fail_value("rvalid_o before read edge", 0, 32'(rvalid_o));
		@(posedge clk);
		rd_i <= 1'b0;
		@(negedge clk);
		checks++;
		assert (rvalid_o === 1'b1) else fail_value("rvalid_o after read edge", 1, 32'(rvalid_o));
		d = rdata_o;
	endtask

	task automatic check_int1(output logic [TOM_DATA_W-1:0] d);
		reg_read(ADDR_INT1, d);
		checks++;
		assert ((d & INT1_CHK_MASK) === snap_int1)
		else fail_value("INT1 enables and pending", 32'(snap_int1), 32'(d & INT1_CHK_MASK));
	endtask

	initial begin
		logic [TOM_DATA_W-1:0] d;
		logic [TOM_DATA_W-1:0] val;
		logic [TOM_ADDR_W-1:0] reg_addrs [10];
		logic [TOM_ADDR_W-1:0] bad_addrs [4];
		int hp;
		int vp;
		int p;
		int dv;
		int v0;
		int t0;
		int polls;
		void'($urandom(32'h9d812bc4));
		errors = 0;
		checks = 0;
		last_vint_cyc = -100;
		vid_chk = 1'b0;
		rst_n_i = 1'b0;
		addr_i = '0;
		wdata_i = '0;
		wr_i = 1'b0;
		rd_i = 1'b0;
		dint_i = 1'b0;
		reg_addrs = '{ADDR_VMODE, ADDR_HP, ADDR_HBB, ADDR_HS, ADDR_VP,
			ADDR_VBB, ADDR_VS, ADDR_VI, ADDR_PIT0, ADDR_PIT1};
		bad_addrs = '{8'h00, 8'h29, 8'h2A, 8'hFF};
		repeat (8) @(posedge clk);
		rst_n_i <= 1'b1;

		// Reset state of the outputs
		@(negedge clk);
		checks++;
		assert ({intl_o, hsync_n_o, vsync_n_o, blank_o, rvalid_o} === 5'b11110)
		else fail_value("outputs after reset {intl,hs_n,vs_n,blank,rvalid}", 32'h1e,
			32'({intl_o, hsync_n_o, vsync_n_o, blank_o, rvalid_o}));
		checks++;
		assert (rdata_o === '0) else fail_value("rdata_o after reset", 0, 32'(rdata_o));

		// Random readback of every writable register, holes read zero
		for (int i = 0; i < 10; i++) begin
			val = 16'($urandom);
			reg_write(reg_addrs[i], val);
			reg_read(reg_addrs[i], d);
			checks++;
			assert (d === (val & readback_mask(reg_addrs[i])))
			else fail_value("register readback", 32'(val & readback_mask(reg_addrs[i])), 32'(d));
		end
		for (int i = 0; i < 4; i++) begin
			reg_read(bad_addrs[i], d);
			checks++;
			assert (d === '0) else fail_value("unmapped address read", 0, 32'(d));
		end

		// Stop the beam so DUT and model meet at 0, then a small random frame
		reg_write(ADDR_VMODE, 16'h0000);
		@(posedge clk);
		vid_chk = 1'b1;
		hp = 4 + $urandom % 8;
		vp = 3 + $urandom % 4;
		reg_write(ADDR_HP, 16'(hp));
		reg_write(ADDR_HBB, 16'(1 + $urandom % hp));
		reg_write(ADDR_HS, 16'(1 + $urandom % hp));
		reg_write(ADDR_VP, 16'(vp));
		reg_write(ADDR_VBB, 16'(1 + $urandom % vp));
		reg_write(ADDR_VS, 16'(1 + $urandom % vp));
		reg_write(ADDR_VI, 16'($urandom % (vp + 1)));
		reg_write(ADDR_VMODE, 16'h0001);
		// Four cycles per pass, a little over two frames
		repeat ((hp + 1) * (vp + 1) / 2 + 1) begin
			reg_read(ADDR_HC, d);
			checks++;
			assert (d === {{(TOM_DATA_W-TOM_CNT_W){1'b0}}, snap_hc})
			else fail_value("HC read", 32'(snap_hc), 32'(d));
			reg_read(ADDR_VC, d);
			checks++;
			assert (d === {{(TOM_DATA_W-TOM_CNT_W){1'b0}}, snap_vc})
			else fail_value("VC read", 32'(snap_vc), 32'(d));
		end

		// Vertical interrupt, pending then registered line two cycles after line VI
		reg_write(ADDR_INT1, 16'h0701);
		@(negedge clk);
		while (intl_o !== 1'b0) @(negedge clk);
		checks++;
		assert (cycles == last_vint_cyc + 2)
		else fail_value("intl_o cycle after line VI", 32'(last_vint_cyc + 2), 32'(cycles));
		reg_write(ADDR_INT1, 16'h0101);
		@(negedge clk);
		checks++;
		assert (intl_o === 1'b0) else fail_value("intl_o on the clear cycle", 0, 32'(intl_o));
		@(negedge clk);
		checks++;
		assert (intl_o === 1'b1) else fail_value("intl_o after clear", 1, 32'(intl_o));
		// Enable off, pending still sets and the line stays high
		reg_write(ADDR_INT1, 16'h0700);
		v0 = last_vint_cyc;
		while (last_vint_cyc == v0) begin
			@(negedge clk);
			checks++;
			assert (intl_o === 1'b1) else fail_value("intl_o with enable clear", 1, 32'(intl_o));
		end
		repeat (3) begin
			@(negedge clk);
			checks++;
			assert (intl_o === 1'b1) else fail_value("intl_o with enable clear", 1, 32'(intl_o));
		end
		check_int1(d);
		checks++;
		assert (d[INT_VID] === 1'b1) else fail_value("video pending bit", 1, 32'(d[INT_VID]));

		// Timer period, exact phase comes from the model on every INT1 read
		p = 1 + $urandom % 4;
		dv = 1 + $urandom % 3;
		reg_write(ADDR_PIT1, 16'(dv));
		reg_write(ADDR_PIT0, 16'(p));
		repeat (3) begin
			reg_write(ADDR_INT1, 16'h0200);
			polls = 0;
			d = '0;
			while (d[INT_PIT] !== 1'b1 && polls <= (p + 1) * (dv + 1)) begin
				check_int1(d);
				polls++;
			end
			checks++;
			assert (d[INT_PIT] === 1'b1) else fail_event("timer pending bit never set after clear");
		end

		// DSP edge through the synchronizer, a held level gives one event
		reg_write(ADDR_INT1, 16'h0400);
		@(posedge clk);
		dint_i <= 1'b1;
		@(negedge clk);
		t0 = cycles;
		d = '0;
		while (d[INT_DSP] !== 1'b1 && cycles < t0 + 8) begin
			check_int1(d);
		end
		checks++;
		assert (d[INT_DSP] === 1'b1 && snap_cyc <= t0 + 4)
		else fail_event("DSP pending not set within 4 cycles of dint_i rising");
		reg_write(ADDR_INT1, 16'h0400);
		repeat (3) begin
			check_int1(d);
			checks++;
			assert (d[INT_DSP] === 1'b0)
			else fail_value("DSP pending with dint_i held high", 0, 32'(d[INT_DSP]));
		end
		@(posedge clk);
		dint_i <= 1'b0;
		@(negedge clk);

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: tom_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video timing and interrupt block top, register port and read bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tom_top (
	input  logic                           clk,
	input  logic                           rst_n_i,
	input  logic [tom_pkg::TOM_ADDR_W-1:0] addr_i,
	input  logic [tom_pkg::TOM_DATA_W-1:0] wdata_i,
	input  logic                           wr_i,
	input  logic                           rd_i,
	input  logic                           dint_i,
	output logic [tom_pkg::TOM_DATA_W-1:0] rdata_o,
	output logic                           rvalid_o,
	output logic                           hblank_o,
	output logic                           vblank_o,
	output logic                           blank_o,
	output logic                           hsync_n_o,
	output logic                           vsync_n_o,
	output logic                           intl_o
);
	import tom_pkg::*;

	tom_reg_e reg_sel;

	// Read bus sources, each a value with its own enable
	logic [TOM_DATA_W-1:0] vid_rd_data;
	logic vid_rd_en;
	logic [TOM_DATA_W-1:0] pit_rd_data;
	logic pit_rd_en;
	logic [TOM_DATA_W-1:0] int_rd_data;
	logic int_rd_en;
	logic [TOM_DATA_W-1:0] rd_bus;

	logic [TOM_INT_N-1:0] irq;
	logic vint;
	logic tick;

	logic [TOM_DATA_W-1:0] rdata_q;
	logic rvalid_q;

	tom_reg_decode u_decode (
		.addr_i    (addr_i),
		.reg_sel_o (reg_sel)
	);

	tom_video_timing u_vid (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.reg_sel_i (reg_sel),
		.wr_i      (wr_i),
		.wdata_i   (wdata_i),
		.rd_data_o (vid_rd_data),
		.rd_en_o   (vid_rd_en),
		.vint_o    (vint),
		.hblank_o  (hblank_o),
		.vblank_o  (vblank_o),
		.blank_o   (blank_o),
		.hsync_n_o (hsync_n_o),
		.vsync_n_o (vsync_n_o)
	);

	tom_pit u_pit (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.reg_sel_i (reg_sel),
		.wr_i      (wr_i),
		.wdata_i   (wdata_i),
		.rd_data_o (pit_rd_data),
		.rd_en_o   (pit_rd_en),
		.tick_o    (tick)
	);

	// Event vector in INT_ bit order, DSP edge is found inside the controller
	always_comb begin
		irq = '0;
		irq[INT_VID] = vint;
		irq[INT_PIT] = tick;
		irq[INT_DSP] = 1'b0;
	end

	tom_int_ctrl u_int (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.reg_sel_i (reg_sel),
		.wr_i      (wr_i),
		.wdata_i   (wdata_i),
		.irq_i     (irq),
		.dint_i    (dint_i),
		.rd_data_o (int_rd_data),
		.rd_en_o   (int_rd_en),
		.intl_o    (intl_o)
	);

	// OR merge under the enables, nothing enabled reads as zero
	assign rd_bus = (vid_rd_en ? vid_rd_data : '0)
		| (pit_rd_en ? pit_rd_data : '0)
		| (int_rd_en ? int_rd_data : '0);

	// Data captured on the rd_i edge, valid one cycle later
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rdata_q <= '0;
		end else if (rd_i) begin
			rdata_q <= rd_bus;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= rd_i;
		end
	end

	assign rdata_o = rdata_q;
	assign rvalid_o = rvalid_q;

endmodule

// File: tom_int_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Interrupt controller, enable and pending bits, active-low CPU line
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tom_int_ctrl (
	input  logic                           clk,
	input  logic                           rst_n_i,
	input  tom_pkg::tom_reg_e              reg_sel_i,
	input  logic                           wr_i,
	input  logic [tom_pkg::TOM_DATA_W-1:0] wdata_i,
	input  logic [tom_pkg::TOM_INT_N-1:0]  irq_i,
	input  logic                           dint_i,
	output logic [tom_pkg::TOM_DATA_W-1:0] rd_data_o,
	output logic                           rd_en_o,
	output logic                           intl_o
);
	import tom_pkg::*;

	// Two synchronizer stages then one more for the edge compare
	logic [2:0] dint_q;
	logic dint_rise;

	logic [TOM_INT_N-1:0] evt;
	logic [TOM_INT_N-1:0] int_en_q;
	logic [TOM_INT_N-1:0] int_pend_q;
	logic [TOM_INT_N-1:0] int_clr;
	logic int1_wr;
	logic intl_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dint_q <= '0;
		end else begin
			dint_q <= {dint_q[1:0], dint_i};
		end
	end

	// Level held high gives a single event
	assign dint_rise = dint_q[1] & ~dint_q[2];

	// DSP slot of irq_i comes in tied low, the edge fills it
	always_comb begin
		evt = irq_i;
		evt[INT_DSP] = irq_i[INT_DSP] | dint_rise;
	end

	assign int1_wr = wr_i && (reg_sel_i == REG_INT1);
	assign int_clr = int1_wr ? wdata_i[INT_CLR_LSB +: TOM_INT_N] : '0;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			int_en_q <= '0;
			int_pend_q <= '0;
		end else begin
			// Low bits of an INT1 write load the enables
			if (int1_wr) begin
				int_en_q <= wdata_i[TOM_INT_N-1:0];
			end
			// OR-in after the clear, a new event beats a clear
			int_pend_q <= (int_pend_q & ~int_clr) | evt;
		end
	end

	// Registered CPU line, low while any enabled source is pending
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			intl_q <= 1'b1;
		end else begin
			intl_q <= ~|(int_pend_q & int_en_q);
		end
	end

	assign intl_o = intl_q;

	// INT1 read, pending low, enables where the clear field sits on writes
	always_comb begin
		rd_data_o = '0;
		rd_en_o = (reg_sel_i == REG_INT1);
		if (rd_en_o) begin
			rd_data_o[TOM_INT_N-1:0] = int_pend_q;
			rd_data_o[INT_CLR_LSB +: TOM_INT_N] = int_en_q;
		end
	end

endmodule

// File: tom_pit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Programmable interval timer, prescaler and divider down-counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tom_pit (
	input  logic                           clk,
	input  logic                           rst_n_i,
	input  tom_pkg::tom_reg_e              reg_sel_i,
	input  logic                           wr_i,
	input  logic [tom_pkg::TOM_DATA_W-1:0] wdata_i,
	output logic [tom_pkg::TOM_DATA_W-1:0] rd_data_o,
	output logic                           rd_en_o,
	output logic                           tick_o
);
	import tom_pkg::*;

	// Programmed values
	logic [TOM_DATA_W-1:0] pit0_q;
	logic [TOM_DATA_W-1:0] pit1_q;

	// Live down-counters
	logic [TOM_DATA_W-1:0] presc_q;
	logic [TOM_DATA_W-1:0] div_q;

	logic wr_pit0;
	logic wr_pit1;
	logic run;
	logic presc_zero;
	logic div_zero;

	assign wr_pit0 = wr_i && (reg_sel_i == REG_PIT0);
	assign wr_pit1 = wr_i && (reg_sel_i == REG_PIT1);

	// Zero in either register stops the timer
	assign run = (pit0_q != '0) && (pit1_q != '0);
	assign presc_zero = (presc_q == '0);
	assign div_zero = (div_q == '0);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pit0_q <= '0;
			pit1_q <= '0;
			presc_q <= '0;
			div_q <= '0;
		end else begin
			if (wr_pit0) begin
				pit0_q <= wdata_i;
			end
			if (wr_pit1) begin
				pit1_q <= wdata_i;
			end
			if (wr_pit0 || wr_pit1) begin
				// Restart the count using the value just written
				presc_q <= wr_pit0 ? wdata_i : pit0_q;
				div_q <= wr_pit1 ? wdata_i : pit1_q;
			end else if (presc_zero) begin
				// PIT0+1 clocks per divider step
				presc_q <= pit0_q;
				div_q <= div_zero ? pit1_q : div_q - 1'b1;
			end else begin
				presc_q <= presc_q - 1'b1;
			end
		end
	end

	// One clock wide, both counters pass through zero together once a period
	assign tick_o = run & presc_zero & div_zero;

	always_comb begin
		rd_data_o = '0;
		rd_en_o = 1'b1;
		case (reg_sel_i)
			REG_PIT0: rd_data_o = pit0_q;
			REG_PIT1: rd_data_o = pit1_q;
			default: rd_en_o = 1'b0;
		endcase
	end

endmodule

// File: tom_video_timing.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video timing, H/V counters with blanking, sync and vertical interrupt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tom_video_timing (
	input  logic                           clk,
	input  logic                           rst_n_i,
	input  tom_pkg::tom_reg_e              reg_sel_i,
	input  logic                           wr_i,
	input  logic [tom_pkg::TOM_DATA_W-1:0] wdata_i,
	output logic [tom_pkg::TOM_DATA_W-1:0] rd_data_o,
	output logic                           rd_en_o,
	output logic                           vint_o,
	output logic                           hblank_o,
	output logic                           vblank_o,
	output logic                           blank_o,
	output logic                           hsync_n_o,
	output logic                           vsync_n_o
);
	import tom_pkg::*;

	// Mode register kept at full width, only VIDEN is used here
	logic [TOM_DATA_W-1:0] vmode_q;

	// Horizontal timing, in clocks from start of line
	logic [TOM_CNT_W-1:0] hp_q;
	logic [TOM_CNT_W-1:0] hbb_q;
	logic [TOM_CNT_W-1:0] hs_q;

	// Vertical timing, in lines from start of frame
	logic [TOM_CNT_W-1:0] vp_q;
	logic [TOM_CNT_W-1:0] vbb_q;
	logic [TOM_CNT_W-1:0] vs_q;
	logic [TOM_CNT_W-1:0] vi_q;

	// Beam position
	logic [TOM_CNT_W-1:0] hc_q;
	logic [TOM_CNT_W-1:0] vc_q;

	logic viden;
	logic line_end;
	logic frame_end;

	assign viden = vmode_q[VMODE_VIDEN];

	// Compare with >= so a period shrunk under the count still wraps
	assign line_end = (hc_q >= hp_q);
	assign frame_end = (vc_q >= vp_q);

	// Host writes to the timing registers
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			vmode_q <= '0;
			hp_q <= '0;
			hbb_q <= '0;
			hs_q <= '0;
			vp_q <= '0;
			vbb_q <= '0;
			vs_q <= '0;
			vi_q <= '0;
		end else if (wr_i) begin
			case (reg_sel_i)
				REG_VMODE: vmode_q <= wdata_i;
				REG_HP: hp_q <= wdata_i[TOM_CNT_W-1:0];
				REG_HBB: hbb_q <= wdata_i[TOM_CNT_W-1:0];
				REG_HS: hs_q <= wdata_i[TOM_CNT_W-1:0];
				REG_VP: vp_q <= wdata_i[TOM_CNT_W-1:0];
				REG_VBB: vbb_q <= wdata_i[TOM_CNT_W-1:0];
				REG_VS: vs_q <= wdata_i[TOM_CNT_W-1:0];
				REG_VI: vi_q <= wdata_i[TOM_CNT_W-1:0];
				// HC and VC are read only, rest belongs elsewhere
				default: ;
			endcase
		end
	end

	// Beam counters
	// VIDEN is seen one edge after its write, so 0 holds for that cycle
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hc_q <= '0;
			vc_q <= '0;
		end else if (!viden) begin
			hc_q <= '0;
			vc_q <= '0;
		end else if (line_end) begin
			hc_q <= '0;
			// Line wrap steps the vertical count
			if (frame_end) begin
				vc_q <= '0;
			end else begin
				vc_q <= vc_q + 1'b1;
			end
		end else begin
			hc_q <= hc_q + 1'b1;
		end
	end

	// Blanking is the tail of each line and of each frame
	// Forced on while the counters are stopped
	assign hblank_o = ~viden | (hc_q >= hbb_q);
	assign vblank_o = ~viden | (vc_q >= vbb_q);
	assign blank_o = hblank_o | vblank_o;

	// Active low syncs run from the start point to the wrap
	assign hsync_n_o = ~(viden & (hc_q >= hs_q));
	assign vsync_n_o = ~(viden & (vc_q >= vs_q));

	// First clock of line VI
	assign vint_o = viden & (hc_q == '0) & (vc_q == vi_q);

	// Read side of the register bus, narrow values zero-extended
	always_comb begin
		rd_data_o = '0;
		rd_en_o = 1'b1;
		case (reg_sel_i)
			REG_VMODE: rd_data_o = vmode_q;
			REG_HP: rd_data_o[TOM_CNT_W-1:0] = hp_q;
			REG_HBB: rd_data_o[TOM_CNT_W-1:0] = hbb_q;
			REG_HS: rd_data_o[TOM_CNT_W-1:0] = hs_q;
			REG_VP: rd_data_o[TOM_CNT_W-1:0] = vp_q;
			REG_VBB: rd_data_o[TOM_CNT_W-1:0] = vbb_q;
			REG_VS: rd_data_o[TOM_CNT_W-1:0] = vs_q;
			REG_VI: rd_data_o[TOM_CNT_W-1:0] = vi_q;
			REG_HC: rd_data_o[TOM_CNT_W-1:0] = hc_q;
			REG_VC: rd_data_o[TOM_CNT_W-1:0] = vc_q;
			default: rd_en_o = 1'b0;
		endcase
	end

endmodule

// File: tom_reg_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register address decode, byte address to register select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tom_reg_decode (
	input  logic [tom_pkg::TOM_ADDR_W-1:0] addr_i,
	output tom_pkg::tom_reg_e              reg_sel_o
);
	import tom_pkg::*;

	// Purely combinational, same select serves reads and writes
	// Owners qualify it with wr_i, the top level with rd_i
	always_comb begin
		case (addr_i)
			// Video mode and horizontal timing
			ADDR_VMODE: reg_sel_o = REG_VMODE;
			ADDR_HP: reg_sel_o = REG_HP;
			ADDR_HBB: reg_sel_o = REG_HBB;
			ADDR_HS: reg_sel_o = REG_HS;

			// Vertical timing and interrupt line
			ADDR_VP: reg_sel_o = REG_VP;
			ADDR_VBB: reg_sel_o = REG_VBB;
			ADDR_VS: reg_sel_o = REG_VS;
			ADDR_VI: reg_sel_o = REG_VI;

			// Live counters, read only
			ADDR_HC: reg_sel_o = REG_HC;
			ADDR_VC: reg_sel_o = REG_VC;

			// Interval timer
			ADDR_PIT0: reg_sel_o = REG_PIT0;
			ADDR_PIT1: reg_sel_o = REG_PIT1;

			// Interrupt enable, clear and pending
			ADDR_INT1: reg_sel_o = REG_INT1;

			// Every mapped offset is even
			// so odd addresses land here along with holes in the map
			default: reg_sel_o = REG_NONE;
		endcase
	end

endmodule

// File: tom_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the video timing and interrupt block
// Widths, register map offsets, register select enum, interrupt bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package tom_pkg;

	// Host register port widths
	localparam int TOM_DATA_W = 16;
	localparam int TOM_ADDR_W = 8;

	// Video counters and timing registers
	localparam int TOM_CNT_W = 11;

	// Interrupt sources, one bit each in enable and pending
	localparam int TOM_INT_N = 3;
	localparam int INT_VID = 0;
	localparam int INT_PIT = 1;
	localparam int INT_DSP = 2;

	// INT1 write carries clear bits from here upwards
	// Same field holds the enables on read
	localparam int INT_CLR_LSB = 8;

	// VMODE bit that runs the video counters
	localparam int VMODE_VIDEN = 0;

	// Byte offsets of the host registers, all even
	localparam logic [TOM_ADDR_W-1:0] ADDR_HC = 8'h04;
	localparam logic [TOM_ADDR_W-1:0] ADDR_VC = 8'h06;
	localparam logic [TOM_ADDR_W-1:0] ADDR_VMODE = 8'h28;
	localparam logic [TOM_ADDR_W-1:0] ADDR_HP = 8'h2E;
	localparam logic [TOM_ADDR_W-1:0] ADDR_HBB = 8'h30;
	localparam logic [TOM_ADDR_W-1:0] ADDR_HS = 8'h3A;
	localparam logic [TOM_ADDR_W-1:0] ADDR_VP = 8'h3E;
	localparam logic [TOM_ADDR_W-1:0] ADDR_VBB = 8'h40;
	localparam logic [TOM_ADDR_W-1:0] ADDR_VS = 8'h44;
	localparam logic [TOM_ADDR_W-1:0] ADDR_VI = 8'h4E;
	localparam logic [TOM_ADDR_W-1:0] ADDR_PIT0 = 8'h50;
	localparam logic [TOM_ADDR_W-1:0] ADDR_PIT1 = 8'h52;
	localparam logic [TOM_ADDR_W-1:0] ADDR_INT1 = 8'hE0;

	// Decoded register select
	// REG_NONE covers odd and unmapped addresses
	typedef enum logic [3:0] {
		REG_NONE,
		REG_VMODE,
		REG_HP,
		REG_HBB,
		REG_HS,
		REG_VP,
		REG_VBB,
		REG_VS,
		REG_VI,
		REG_HC,
		REG_VC,
		REG_PIT0,
		REG_PIT1,
		REG_INT1
	} tom_reg_e;

endpackage
